/* include/fltr_coefs.svh */
`ifndef FLTR_COEFS_SVH
`define FLTR_COEFS_SVH

// smooth kernel, centre weighted low pass
`define SMOOTH_C0 8'd4
`define SMOOTH_C1 8'd42
`define SMOOTH_C2 8'd163
`define SMOOTH_C3 8'd255
`define SMOOTH_C4 8'd163
`define SMOOTH_C5 8'd42
`define SMOOTH_C6 8'd4

// sharpen, magnitudes only
`define SHARP_B_C0 8'd29
`define SHARP_B_C1 8'd101
`define SHARP_B_C2 8'd15
`define SHARP_B_C3 8'd235
`define SHARP_B_C4 8'd15
`define SHARP_B_C5 8'd101
`define SHARP_B_C6 8'd29

// edge kernels have a zero centre tap
`define EDGE_D_C0 8'd12
`define EDGE_D_C1 8'd77
`define EDGE_D_C2 8'd148
`define EDGE_D_C3 8'd0
`define EDGE_D_C4 8'd148
`define EDGE_D_C5 8'd77
`define EDGE_D_C6 8'd12

`define EDGE_1_C0 8'd15
`define EDGE_1_C1 8'd25
`define EDGE_1_C2 8'd193
`define EDGE_1_C3 8'd0
`define EDGE_1_C4 8'd193
`define EDGE_1_C5 8'd25
`define EDGE_1_C6 8'd15

`define EDGE_3_C0 8'd9
`define EDGE_3_C1 8'd56
`define EDGE_3_C2 8'd109
`define EDGE_3_C3 8'd0
`define EDGE_3_C4 8'd109
`define EDGE_3_C5 8'd56
`define EDGE_3_C6 8'd9

`endif

/* source/fltr_pkg.sv */
package fltr_pkg;

`include "fltr_coefs.svh"

	localparam int NUM_TAPS = 7;
	localparam int COEF_W = 8;
	localparam int NUM_KERNELS = 5;

	// 5 to 7 are not legal kernels
	typedef enum logic [2:0] {
		KERN_SMOOTH  = 3'd0,
		KERN_SHARP_B = 3'd1,
		KERN_EDGE_D  = 3'd2,
		KERN_EDGE_1  = 3'd3,
		KERN_EDGE_3  = 3'd4
	} kernel_e;

	// register word addresses, 3 reads as zero
	typedef enum logic [1:0] {
		REG_CTRL  = 2'd0,
		REG_COUNT = 2'd1,
		REG_LAST  = 2'd2
	} reg_addr_e;

	// rows follow kernel_e order, columns are taps 0 to 6
	localparam logic [COEF_W-1:0] COEF_TAB [NUM_KERNELS][NUM_TAPS] = '{
		'{`SMOOTH_C0, `SMOOTH_C1, `SMOOTH_C2, `SMOOTH_C3, `SMOOTH_C4, `SMOOTH_C5, `SMOOTH_C6},
		'{`SHARP_B_C0, `SHARP_B_C1, `SHARP_B_C2, `SHARP_B_C3, `SHARP_B_C4, `SHARP_B_C5,
			`SHARP_B_C6},
		'{`EDGE_D_C0, `EDGE_D_C1, `EDGE_D_C2, `EDGE_D_C3, `EDGE_D_C4, `EDGE_D_C5, `EDGE_D_C6},
		'{`EDGE_1_C0, `EDGE_1_C1, `EDGE_1_C2, `EDGE_1_C3, `EDGE_1_C4, `EDGE_1_C5, `EDGE_1_C6},
		'{`EDGE_3_C0, `EDGE_3_C1, `EDGE_3_C2, `EDGE_3_C3, `EDGE_3_C4, `EDGE_3_C5, `EDGE_3_C6}
	};

	// zero for an illegal kernel or a tap out of range
	function automatic logic [COEF_W-1:0] kern_coef(kernel_e kern, int tap);
		logic [COEF_W-1:0] coef;
		coef = '0;
		if (kern <= KERN_EDGE_3 && tap >= 0 && tap < NUM_TAPS)
		begin
			coef = COEF_TAB[kern][tap];
		end
		return coef;
	endfunction

endpackage

/* source/fltr_window.sv */
module fltr_window #(
	parameter int PIX_W = 8
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                enable,
	input  logic [PIX_W-1:0]                    pix_data,
	input  logic                                pix_valid,
	output logic [fltr_pkg::NUM_TAPS*PIX_W-1:0] win_taps,
	output logic                                win_valid
);
	import fltr_pkg::*;

	localparam int WIN_W = NUM_TAPS * PIX_W;
	localparam int FILL_W = $clog2(NUM_TAPS + 1);

	logic [WIN_W-1:0]  win_q;
	logic [FILL_W-1:0] fill_q;
	logic              take;

	assign take = enable && pix_valid;

	// newest pixel enters at tap 6, tap 0 is the oldest
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			win_q <= {pix_data, win_q[WIN_W-1:PIX_W]};
		end
	end

	// fill count saturates at seven, held at zero while disabled
	always_ff @(posedge clk)
	begin
		if (!rst_n || !enable)
		begin
			fill_q <= '0;
			win_valid <= 1'b0;
		end
		else
		begin
			if (pix_valid && fill_q != FILL_W'(NUM_TAPS))
			begin
				fill_q <= fill_q + 1'b1;
			end
			win_valid <= pix_valid && (fill_q >= FILL_W'(NUM_TAPS - 1));
		end
	end

	assign win_taps = win_q;

	// a window is only ever completed by an accepted pixel
	a_win_needs_pix: assert property (@(posedge clk) disable iff (!rst_n)
		win_valid |-> $past(pix_valid && enable));

endmodule

/* source/fltr_compute.sv */
module fltr_compute #(
	parameter int PIX_W = 8
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  fltr_pkg::kernel_e                   kernel,
	input  logic [fltr_pkg::NUM_TAPS*PIX_W-1:0] win_taps,
	input  logic                                win_valid,
	output logic [15:0]                         res_data,
	output logic                                res_valid
);
	import fltr_pkg::*;

	localparam int PROD_W = PIX_W + COEF_W;
	// room for seven products plus one spare bit
	localparam int SUM_W = PROD_W + 4;
	localparam int RES_W = 16;
	localparam int SHIFT = 3;
	localparam int STAGES = 3;

	logic [PROD_W-1:0] prod_q [NUM_TAPS];
	logic [SUM_W-1:0]  sum_d;
	logic [SUM_W-1:0]  sum_q;
	logic [STAGES-1:0] vld_q;

	// stage 1 multiplies each tap by its constant
	// kernel is sampled here so a change applies to the next window
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NUM_TAPS; i++)
		begin
			prod_q[i] <= PROD_W'(win_taps[i*PIX_W +: PIX_W]) * PROD_W'(kern_coef(kernel, i));
		end
	end

	// unsigned adder tree
	always_comb
	begin
		sum_d = '0;
		for (int i = 0; i < NUM_TAPS; i++)
		begin
			sum_d = sum_d + SUM_W'(prod_q[i]);
		end
	end

	// stage 2 registers the sum
	always_ff @(posedge clk)
	begin
		sum_q <= sum_d;
	end

	// stage 3 divides by eight
	always_ff @(posedge clk)
	begin
		res_data <= sum_q[RES_W+SHIFT-1:SHIFT];
	end

	// valid marker riding alongside the data
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			vld_q <= '0;
		end
		else
		begin
			vld_q <= {vld_q[STAGES-2:0], win_valid};
		end
	end

	assign res_valid = vld_q[STAGES-1];

	// register slave must never let an illegal kernel through
	a_kernel_legal: assert property (@(posedge clk) disable iff (!rst_n)
		kernel <= KERN_EDGE_3);

	a_res_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(res_valid));

endmodule

/* source/fltr_wb_regs.sv */
module fltr_wb_regs #(
	parameter int COUNT_W = 16
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [1:0]        wb_adr,
	input  logic [15:0]       wb_dat_i,
	output logic [15:0]       wb_dat_o,
	output logic              wb_ack,
	input  logic [15:0]       res_data,
	input  logic              res_valid,
	output logic              enable,
	output fltr_pkg::kernel_e kernel
);
	import fltr_pkg::*;

	logic               req;
	logic               wr_ctrl;
	logic               wr_count;
	reg_addr_e          addr;
	logic [2:0]         kern_wr;
	logic [COUNT_W-1:0] count_q;
	logic [15:0]        last_q;
	logic [15:0]        rd_data;

	// new request, not the tail of one already acked
	assign req = wb_cyc && wb_stb && !wb_ack;
	assign addr = reg_addr_e'(wb_adr);
	assign kern_wr = wb_dat_i[3:1];
	assign wr_ctrl = req && wb_we && (addr == REG_CTRL);
	assign wr_count = req && wb_we && (addr == REG_COUNT);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wb_ack <= 1'b0;
		end
		else
		begin
			wb_ack <= req;
		end
	end

	// control, bad kernel codes are dropped but enable still lands
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			enable <= 1'b0;
			kernel <= KERN_SMOOTH;
		end
		else if (wr_ctrl)
		begin
			enable <= wb_dat_i[0];
			if (kern_wr <= 3'(KERN_EDGE_3))
			begin
				kernel <= kernel_e'(kern_wr);
			end
		end
	end

	// result count wraps, a write of any value clears it
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			count_q <= '0;
			last_q <= '0;
		end
		else
		begin
			if (wr_count)
			begin
				count_q <= '0;
			end
			else if (res_valid)
			begin
				count_q <= count_q + 1'b1;
			end
			if (res_valid)
			begin
				last_q <= res_data;
			end
		end
	end

	always_comb
	begin
		case (addr)
			REG_CTRL:  rd_data = {12'd0, kernel, enable};
			REG_COUNT: rd_data = 16'(count_q);
			REG_LAST:  rd_data = last_q;
			default:   rd_data = '0;
		endcase
	end

	// read data held for the ack cycle
	always_ff @(posedge clk)
	begin
		if (req)
		begin
			wb_dat_o <= rd_data;
		end
	end

	a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> $past(wb_cyc && wb_stb));

endmodule

/* source/fltr_top.sv */
module fltr_top #(
	parameter int PIX_W = 8,
	parameter int COUNT_W = 16
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [PIX_W-1:0] pix_data,
	input  logic             pix_valid,
	output logic [15:0]      res_data,
	output logic             res_valid,
	input  logic             wb_cyc,
	input  logic             wb_stb,
	input  logic             wb_we,
	input  logic [1:0]       wb_adr,
	input  logic [15:0]      wb_dat_i,
	output logic [15:0]      wb_dat_o,
	output logic             wb_ack
);
	import fltr_pkg::*;

	logic                      enable;
	kernel_e                   kernel;
	logic [NUM_TAPS*PIX_W-1:0] win_taps;
	logic                      win_valid;

	// pixel stream into the seven tap window
	fltr_window #(
		.PIX_W(PIX_W)
	) u_window (
		.clk       (clk),
		.rst_n     (rst_n),
		.enable    (enable),
		.pix_data  (pix_data),
		.pix_valid (pix_valid),
		.win_taps  (win_taps),
		.win_valid (win_valid)
	);

	// three stage multiply and accumulate
	fltr_compute #(
		.PIX_W(PIX_W)
	) u_compute (
		.clk       (clk),
		.rst_n     (rst_n),
		.kernel    (kernel),
		.win_taps  (win_taps),
		.win_valid (win_valid),
		.res_data  (res_data),
		.res_valid (res_valid)
	);

	fltr_wb_regs #(
		.COUNT_W(COUNT_W)
	) u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack    (wb_ack),
		.res_data  (res_data),
		.res_valid (res_valid),
		.enable    (enable),
		.kernel    (kernel)
	);

endmodule

/* sim/fltr_checker.sv */
module fltr_checker #(
	parameter int PIX_W = 8
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [PIX_W-1:0] pix_data,
	input  logic             pix_valid,
	input  logic [15:0]      res_data,
	input  logic             res_valid,
	input  logic             wb_cyc,
	input  logic             wb_stb,
	input  logic             wb_we,
	input  logic [1:0]       wb_adr,
	input  logic [15:0]      wb_dat_i,
	input  logic [15:0]      wb_dat_o,
	input  logic             wb_ack,
	input  int               tb_errs,
	input  logic             report,
	output logic             idle,
	output int               err_total
);
	timeunit 1ns;
	timeprecision 100ps;
	import fltr_pkg::*;

	// pixel sampled to result sampled, in clock edges
	localparam int LATENCY = 4;
	localparam int WIN_W = NUM_TAPS * PIX_W;

	logic [WIN_W-1:0] hist;
	logic [WIN_W-1:0] win_snap;
	logic             win_pend;
	int               win_cycle;
	int               fill;
	int               cycle = 0;
	logic             en_m;
	kernel_e          kern_m;
	logic [15:0]      cnt_m;
	logic [15:0]      last_m;
	logic             req;
	logic             ack_exp;
	logic             rd_exp_vld;
	logic [15:0]      rd_exp;
	int               due_q[$];
	logic [15:0]      val_q[$];
	int               data_errs = 0;
	int               timing_errs = 0;
	int               bus_errs = 0;
	logic             reported = 1'b0;

	// sum of coefficient times pixel, divided by eight
	function automatic logic [15:0] filter_model(input logic [WIN_W-1:0] win, input kernel_e kern);
		int unsigned acc;
		acc = 0;
		for (int i = 0; i < NUM_TAPS; i++)
		begin
			acc = acc + 32'(kern_coef(kern, i)) * 32'(win[i*PIX_W +: PIX_W]);
		end
		return 16'(acc >> 3);
	endfunction

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			en_m = 1'b0;
			kern_m = KERN_SMOOTH;
			cnt_m = '0;
			last_m = '0;
			fill = 0;
			win_pend = 1'b0;
			ack_exp = 1'b0;
			rd_exp_vld = 1'b0;
			due_q.delete();
			val_q.delete();
			idle = 1'b1;
		end
		else
		begin
			cycle++;
			req = wb_cyc && wb_stb && !wb_ack;
			// answer to the request sampled one edge earlier
			if (wb_ack && !ack_exp)
			begin
				$display("%0t: wb_ack raised without a request", $time);
				bus_errs++;
			end
			else if (ack_exp && !wb_ack)
			begin
				$display("%0t: request not acknowledged in the next cycle", $time);
				bus_errs++;
			end
			else if (wb_ack && rd_exp_vld && wb_dat_o !== rd_exp)
			begin
				$display("FAILED at %0t: wb_dat_o = %h, expected %h", $time, wb_dat_o, rd_exp);
				data_errs++;
			end
			ack_exp = req;
			rd_exp_vld = req && !wb_we;
			case (reg_addr_e'(wb_adr))
				REG_CTRL:  rd_exp = {12'd0, kern_m, en_m};
				REG_COUNT: rd_exp = cnt_m;
				REG_LAST:  rd_exp = last_m;
				default:   rd_exp = '0;
			endcase
			if (due_q.size() > 0 && due_q[0] == cycle)
			begin
				if (!res_valid)
				begin
					$display("%0t: result missing %0d cycles after its pixel", $time, LATENCY);
					timing_errs++;
				end
				else if (res_data !== val_q[0])
				begin
					$display("FAILED at %0t: res_data = %h, expected %h", $time, res_data, val_q[0]);
					data_errs++;
				end
				cnt_m = cnt_m + 16'd1;
				last_m = val_q[0];
				void'(due_q.pop_front());
				void'(val_q.pop_front());
			end
			else if (res_valid)
			begin
				$display("%0t: extra result, res_valid high with nothing expected", $time);
				timing_errs++;
			end
			// kernel is taken one edge after the window completes
			if (win_pend)
			begin
				due_q.push_back(win_cycle + LATENCY);
				val_q.push_back(filter_model(win_snap, kern_m));
				win_pend = 1'b0;
			end
			if (!en_m)
			begin
				fill = 0;
			end
			else if (pix_valid)
			begin
				hist = {pix_data, hist[WIN_W-1:PIX_W]};
				if (fill >= NUM_TAPS - 1)
				begin
					win_snap = hist;
					win_pend = 1'b1;
					win_cycle = cycle;
				end
				if (fill < NUM_TAPS)
				begin
					fill++;
				end
			end
			if (req && wb_we && wb_adr == REG_CTRL)
			begin
				en_m = wb_dat_i[0];
				// codes 5 to 7 leave the kernel alone
				if (wb_dat_i[3:1] <= 3'(KERN_EDGE_3))
				begin
					kern_m = kernel_e'(wb_dat_i[3:1]);
				end
			end
			else if (req && wb_we && wb_adr == REG_COUNT)
			begin
				cnt_m = '0;
			end
			idle = (due_q.size() == 0) && !win_pend;
		end
	end

	assign err_total = data_errs + timing_errs + bus_errs + tb_errs;

	always @(posedge clk)
	begin
		if (report && !reported)
		begin
			$display("errors: data %0d, timing %0d, bus %0d, testbench %0d",
				data_errs, timing_errs, bus_errs, tb_errs);
			reported <= 1'b1;
		end
	end

endmodule

/* sim/fltr_tb.sv */
module fltr_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import fltr_pkg::*;

	localparam int PIX_W = 8;
	localparam int COUNT_W = 16;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	localparam int ACK_LIMIT = 8;
	localparam int DRAIN_LIMIT = 32;
	// every pixel of the sequence, gaps can double its cost
	localparam int TOTAL_PIX = 286;
	localparam int WB_OPS = 24;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 * TOTAL_PIX + 4 * WB_OPS + 1000;

	logic             clk;
	logic             rst_n;
	logic [PIX_W-1:0] pix_data;
	logic             pix_valid;
	logic [15:0]      res_data;
	logic             res_valid;
	logic             wb_cyc;
	logic             wb_stb;
	logic             wb_we;
	logic [1:0]       wb_adr;
	logic [15:0]      wb_dat_i;
	logic [15:0]      wb_dat_o;
	logic             wb_ack;
	int               tb_errs;
	logic             report;
	logic             idle;
	int               err_total;
	logic [31:0]      rng;

	fltr_top #(
		.PIX_W(PIX_W),
		.COUNT_W(COUNT_W)
	) UUT (
		.clk(clk), .rst_n(rst_n), .pix_data(pix_data), .pix_valid(pix_valid),
		.res_data(res_data), .res_valid(res_valid), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
		.wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o),
		.wb_ack(wb_ack)
	);

	fltr_checker #(
		.PIX_W(PIX_W)
	) u_checker (
		.clk(clk), .rst_n(rst_n), .pix_data(pix_data), .pix_valid(pix_valid),
		.res_data(res_data), .res_valid(res_valid), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
		.wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o),
		.wb_ack(wb_ack), .tb_errs(tb_errs), .report(report), .idle(idle),
		.err_total(err_total)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [15:0] ctrl_word(input logic [2:0] kern, input logic en);
		return {12'd0, kern, en};
	endfunction

	task automatic wb_cycle(input logic we, input logic [1:0] adr, input logic [15:0] wdat);
		int n;
		n = 0;
		@(negedge clk);
		pix_valid = 1'b0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_i = wdat;
		@(negedge clk);
		while (!wb_ack && n < ACK_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (!wb_ack)
		begin
			$display("%0t: no wb_ack within %0d cycles", $time, ACK_LIMIT);
			tb_errs++;
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic push_pixel(input logic [PIX_W-1:0] d);
		@(negedge clk);
		pix_data = d;
		pix_valid = 1'b1;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(negedge clk);
			pix_valid = 1'b0;
		end
	endtask

	task automatic random_burst(input int count, input logic gaps);
		for (int i = 0; i < count; i++)
		begin
			rng = xorshift32(rng);
			// about one pixel in four waits an extra cycle
			if (gaps && rng[31:30] == 2'b00)
			begin
				idle_cycles(1);
			end
			push_pixel(rng[PIX_W-1:0]);
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		idle_cycles(1);
		while (!idle && n < DRAIN_LIMIT)
		begin
			idle_cycles(1);
			n++;
		end
		if (!idle)
		begin
			$display("%0t: results still pending after %0d idle cycles", $time, DRAIN_LIMIT);
			tb_errs++;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		pix_data = '0;
		pix_valid = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_i = '0;
		tb_errs = 0;
		report = 1'b0;
		rng = 32'hfcb6_36b7;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		// reset values, then pixels with the filter still off
		wb_cycle(1'b0, REG_CTRL, 16'd0);
		wb_cycle(1'b0, REG_COUNT, 16'd0);
		wb_cycle(1'b0, REG_LAST, 16'd0);
		wb_cycle(1'b0, 2'd3, 16'd0);
		random_burst(10, 1'b0);
		wait_drain();
		wb_cycle(1'b1, REG_CTRL, ctrl_word(KERN_SMOOTH, 1'b1));
		random_burst(40, 1'b0);
		wait_drain();
		for (int k = 0; k < 5; k++)
		begin
			wb_cycle(1'b1, REG_CTRL, ctrl_word(3'(k), 1'b1));
			random_burst(30, 1'b1);
			repeat (9) push_pixel('1);
			wait_drain();
		end
		// kernel 6 is rejected, sharp_b stays
		wb_cycle(1'b1, REG_CTRL, ctrl_word(KERN_SHARP_B, 1'b1));
		wb_cycle(1'b1, REG_CTRL, ctrl_word(3'd6, 1'b1));
		wb_cycle(1'b0, REG_CTRL, 16'd0);
		random_burst(20, 1'b1);
		wait_drain();
		// off and on again, six pixels are not yet a window
		wb_cycle(1'b1, REG_CTRL, ctrl_word(KERN_SHARP_B, 1'b0));
		random_burst(5, 1'b0);
		wb_cycle(1'b1, REG_CTRL, ctrl_word(KERN_SHARP_B, 1'b1));
		random_burst(6, 1'b0);
		idle_cycles(8);
		random_burst(10, 1'b0);
		wait_drain();
		wb_cycle(1'b0, REG_COUNT, 16'd0);
		wb_cycle(1'b0, REG_LAST, 16'd0);
		wb_cycle(1'b1, REG_COUNT, 16'h5a5a);
		wb_cycle(1'b1, REG_LAST, 16'hffff);
		wb_cycle(1'b0, REG_COUNT, 16'd0);
		wb_cycle(1'b0, REG_LAST, 16'd0);
		idle_cycles(4);
		report = 1'b1;
		idle_cycles(2);
		if (err_total == 0)
		begin
			$display("RESULT: PASS");
		end
		else
		begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, test sequence did not finish",
			WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* all.f */
+incdir+include
source/fltr_pkg.sv
source/fltr_window.sv
source/fltr_compute.sv
source/fltr_wb_regs.sv
source/fltr_top.sv
sim/fltr_checker.sv
sim/fltr_tb.sv

/* Makefile */
TOP := fltr_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -Wno-fatal -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
